/* hw/rmt_pkg.sv */
package rmt_pkg;

	// stream widths, scaled down to a 64-bit bus
	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;

	// pipeline shape
	localparam int NUM_STAGES = 4;
	localparam int TABLE_DEPTH = 16;
	localparam int TBL_IDX_W = $clog2(TABLE_DEPTH);
	localparam int FIFO_DEPTH_BITS = 4;

	// ethertype-like codes in the top 16 bits of the first beat
	localparam logic [15:0] TYPE_DATA = 16'h0800;
	localparam logic [15:0] TYPE_CTRL = 16'hf1f2;

	typedef logic [DATA_W-1:0] beat_t;
	typedef logic [KEEP_W-1:0] keep_t;
	typedef logic [11:0] vlan_t;
	typedef logic [15:0] container_t;
	typedef logic [3:0] stage_id_t;
	typedef logic [TBL_IDX_W-1:0] tbl_idx_t;

	// one stream beat
	typedef struct packed {
		beat_t data;
		keep_t keep;
		logic  last;
	} axis_t;

	// packet header vector, vlan is the lookup key
	typedef struct packed {
		vlan_t      vlan;
		container_t c0;
		container_t c1;
	} phv_t;

	// encoding matches the op field of a control beat
	typedef enum logic [1:0] {
		act_nop = 2'd0,
		act_add = 2'd1,
		act_set = 2'd2
	} act_op_e;

	// sel 0 picks c0, sel 1 picks c1
	typedef struct packed {
		act_op_e    op;
		logic       sel;
		container_t imm;
	} action_t;

	// decoded control packet
	typedef struct packed {
		logic      valid;
		stage_id_t stage_id;
		tbl_idx_t  entry;
		action_t   act;
	} ctrl_t;

endpackage

/* hw/sync_fifo.sv */
module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH_BITS = 4,
	parameter int MARGIN = 2
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             nearly_full
);

	localparam int DEPTH = 1 << DEPTH_BITS;
	// fill level where writers must stop, leaves MARGIN slots for in-flight entries
	localparam logic [DEPTH_BITS:0] NF_LEVEL = (DEPTH_BITS+1)'(DEPTH - MARGIN);

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_BITS-1:0] wr_ptr;
	logic [DEPTH_BITS-1:0] rd_ptr;
	logic [DEPTH_BITS:0]   count;

	// fall-through, head entry always on dout
	assign dout = mem[rd_ptr];
	assign empty = count == '0;
	assign nearly_full = count >= NF_LEVEL;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// the margin upstream must keep writes away from a full FIFO
	assert property (@(posedge clk) disable iff (!aresetn)
		wr_en |-> count != (DEPTH_BITS+1)'(DEPTH));
	assert property (@(posedge clk) disable iff (!aresetn)
		rd_en |-> !empty);

endmodule

/* hw/pkt_filter.sv */
module pkt_filter import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  axis_t       s_axis,
	input  logic        s_valid,
	output logic        s_ready,
	output axis_t       m_axis,
	output logic        m_valid,
	input  logic        m_ready,
	output ctrl_t       ctrl,
	output logic [31:0] ctrl_token
);

	typedef enum logic [1:0] {
		st_idle,
		st_forward,
		st_discard
	} filt_state_e;

	filt_state_e state;
	filt_state_e state_next;
	logic [15:0] pkt_type;
	vlan_t       vlan;
	logic        take;
	logic        is_data;
	logic        is_ctrl;
	logic        vlan_blocked;
	logic        fwd_beat;

	// all beats wait for a free output slot, control included
	// so a control word never overtakes a data packet held here
	assign s_ready = !m_valid || m_ready;
	assign take = s_valid && s_ready;

	// header fields, only meaningful on a first beat
	assign pkt_type = s_axis.data[63:48];
	assign vlan = s_axis.data[47:36];
	assign is_data = pkt_type == TYPE_DATA;
	assign is_ctrl = pkt_type == TYPE_CTRL;
	assign vlan_blocked = vlan_drop_flags[vlan[4:0]];

	// fate is decided on the first beat and held until last
	always_comb begin
		state_next = state;
		fwd_beat = 1'b0;
		case (state)
			st_idle: begin
				if (is_data && !vlan_blocked) begin
					fwd_beat = 1'b1;
					if (!s_axis.last) begin
						state_next = st_forward;
					end
				end else if (!is_ctrl && !s_axis.last) begin
					// unknown type or blocked vlan, swallow the rest
					state_next = st_discard;
				end
			end
			st_forward: begin
				fwd_beat = 1'b1;
				if (s_axis.last) begin
					state_next = st_idle;
				end
			end
			default: begin
				if (s_axis.last) begin
					state_next = st_idle;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= st_idle;
			m_valid <= 1'b0;
			ctrl <= '0;
			ctrl_token <= '0;
		end else begin
			// ctrl is a one-cycle pulse
			ctrl.valid <= 1'b0;
			if (take) begin
				state <= state_next;
			end
			if (s_ready) begin
				m_valid <= take && fwd_beat;
			end
			if (take && state == st_idle && is_ctrl) begin
				ctrl.valid <= 1'b1;
				ctrl.stage_id <= s_axis.data[47:44];
				ctrl.entry <= s_axis.data[43:40];
				ctrl.act.op <= act_op_e'(s_axis.data[39:38]);
				ctrl.act.sel <= s_axis.data[37];
				ctrl.act.imm <= s_axis.data[36:21];
				ctrl_token <= ctrl_token + 32'd1;
			end
		end
	end

	// output beat payload
	always_ff @(posedge clk) begin
		if (take && fwd_beat) begin
			m_axis <= s_axis;
		end
	end

	// control packets are single-beat
	assert property (@(posedge clk) disable iff (!aresetn)
		take && state == st_idle && is_ctrl |-> s_axis.last);

endmodule

/* hw/phv_parser.sv */
module phv_parser import rmt_pkg::*; (
	input  logic  clk,
	input  logic  aresetn,
	input  axis_t s_axis,
	input  logic  s_valid,
	output logic  s_ready,
	input  logic  pkt_room,
	input  logic  phv_room,
	output axis_t fifo_beat,
	output logic  fifo_wr,
	output phv_t  phv,
	output logic  phv_valid
);

	// high while the next accepted beat opens a packet
	logic first;

	// back-pressure point of the whole pipe
	// stages never stall, so room in both FIFOs is all that matters
	assign s_ready = pkt_room && phv_room;
	assign fifo_wr = s_valid && s_ready;

	// every accepted beat goes to the packet FIFO untouched
	assign fifo_beat = s_axis;

	// header fields from the first beat
	// pad bits 35:32 are not carried
	assign phv.vlan = s_axis.data[47:36];
	assign phv.c0 = s_axis.data[31:16];
	assign phv.c1 = s_axis.data[15:0];

	// one PHV per packet
	assign phv_valid = fifo_wr && first;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first <= 1'b1;
		end else if (fifo_wr) begin
			// next beat is a first beat only after last
			first <= s_axis.last;
		end
	end

endmodule

/* hw/match_stage.sv */
module match_stage import rmt_pkg::*; #(
	parameter stage_id_t STAGE_ID = '0
) (
	input  logic  clk,
	input  logic  aresetn,
	input  phv_t  phv_in,
	input  logic  phv_in_valid,
	input  ctrl_t ctrl_in,
	output phv_t  phv_out,
	output logic  phv_out_valid
);

	action_t    table_mem [TABLE_DEPTH];
	phv_t       phv_q;
	logic       valid_q;
	action_t    act;
	container_t sel_val;
	container_t new_val;
	logic       tbl_wr;

	// control word addressed to this stage
	assign tbl_wr = ctrl_in.valid && ctrl_in.stage_id == STAGE_ID;

	// action table, all entries nop after reset
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < TABLE_DEPTH; i++) begin
				table_mem[i] <= '{op: act_nop, sel: 1'b0, imm: '0};
			end
		end else if (tbl_wr) begin
			table_mem[ctrl_in.entry] <= ctrl_in.act;
		end
	end

	// input register
	always_ff @(posedge clk) begin
		if (!aresetn) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= phv_in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid) begin
			phv_q <= phv_in;
		end
	end

	// direct lookup on the low vlan bits
	// read is from the registered PHV, so a write in the same
	// cycle as the lookup is seen one cycle later
	assign act = table_mem[phv_q.vlan[TBL_IDX_W-1:0]];

	// action unit
	always_comb begin
		sel_val = act.sel ? phv_q.c1 : phv_q.c0;
		case (act.op)
			// wraps modulo 2^16
			act_add: new_val = sel_val + act.imm;
			act_set: new_val = act.imm;
			default: new_val = sel_val;
		endcase
		phv_out = phv_q;
		if (act.sel) begin
			phv_out.c1 = new_val;
		end else begin
			phv_out.c0 = new_val;
		end
	end

	assign phv_out_valid = valid_q;

endmodule

/* hw/phv_deparser.sv */
module phv_deparser import rmt_pkg::*; (
	input  logic  clk,
	input  logic  aresetn,
	input  axis_t pkt_beat,
	input  logic  pkt_empty,
	output logic  pkt_rd,
	input  phv_t  phv,
	input  logic  phv_empty,
	output logic  phv_rd,
	output axis_t m_axis,
	output logic  m_valid,
	input  logic  m_ready
);

	logic  first;
	logic  slot_free;
	axis_t beat_mod;

	// output register empty or draining this cycle
	assign slot_free = !m_valid || m_ready;

	// first beat needs its PHV at the FIFO head
	assign pkt_rd = slot_free && !pkt_empty && (!first || !phv_empty);

	// PHV stays at the head for the whole packet
	assign phv_rd = pkt_rd && pkt_beat.last;

	// splice the containers back, vlan and type untouched
	always_comb begin
		beat_mod = pkt_beat;
		if (first) begin
			beat_mod.data[31:16] = phv.c0;
			beat_mod.data[15:0] = phv.c1;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			first <= 1'b1;
			m_valid <= 1'b0;
		end else begin
			if (pkt_rd) begin
				first <= pkt_beat.last;
			end
			if (slot_free) begin
				m_valid <= pkt_rd;
			end
		end
	end

	// output payload, held while the sink stalls
	always_ff @(posedge clk) begin
		if (pkt_rd) begin
			m_axis <= beat_mod;
		end
	end

	// packet and PHV FIFOs stay paired one PHV per packet
	// a queued PHV always has its first beat queued ahead of it
	assert property (@(posedge clk) disable iff (!aresetn)
		first && !phv_empty |-> !pkt_empty);

endmodule

/* hw/rmt_top.sv */
module rmt_top import rmt_pkg::*; (
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	output logic [31:0] ctrl_token,
	input  beat_t       s_axis_tdata,
	input  keep_t       s_axis_tkeep,
	input  logic        s_axis_tvalid,
	output logic        s_axis_tready,
	input  logic        s_axis_tlast,
	output beat_t       m_axis_tdata,
	output keep_t       m_axis_tkeep,
	output logic        m_axis_tvalid,
	input  logic        m_axis_tready,
	output logic        m_axis_tlast
);

	axis_t s_beat;
	axis_t filt_beat;
	axis_t pkt_in;
	axis_t pkt_out;
	axis_t m_beat;
	logic  filt_valid;
	logic  filt_ready;
	logic  pkt_wr;
	logic  pkt_rd;
	logic  pkt_empty;
	logic  pkt_nf;
	phv_t  phv_head;
	logic  phv_rd;
	logic  phv_empty;
	logic  phv_nf;

	// index 0 is the parser or filter output, index i+1 the output of stage i
	phv_t  stg_phv [NUM_STAGES+1];
	logic  stg_valid [NUM_STAGES+1];
	ctrl_t ctrl_chain [NUM_STAGES+1];

	assign s_beat = '{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};
	assign m_axis_tdata = m_beat.data;
	assign m_axis_tkeep = m_beat.keep;
	assign m_axis_tlast = m_beat.last;

	pkt_filter u_filter (
		.clk(clk), .aresetn(aresetn), .vlan_drop_flags(vlan_drop_flags),
		.s_axis(s_beat), .s_valid(s_axis_tvalid), .s_ready(s_axis_tready),
		.m_axis(filt_beat), .m_valid(filt_valid), .m_ready(filt_ready),
		.ctrl(ctrl_chain[0]), .ctrl_token(ctrl_token)
	);

	phv_parser u_parser (
		.clk(clk), .aresetn(aresetn),
		.s_axis(filt_beat), .s_valid(filt_valid), .s_ready(filt_ready),
		.pkt_room(!pkt_nf), .phv_room(!phv_nf),
		.fifo_beat(pkt_in), .fifo_wr(pkt_wr),
		.phv(stg_phv[0]), .phv_valid(stg_valid[0])
	);

	// control chain keeps pace with the PHV chain, one register per stage
	for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
		always_ff @(posedge clk) begin
			if (!aresetn) begin
				ctrl_chain[i+1].valid <= 1'b0;
			end else begin
				ctrl_chain[i+1] <= ctrl_chain[i];
			end
		end

		match_stage #(.STAGE_ID(stage_id_t'(i))) u_stage (
			.clk(clk), .aresetn(aresetn),
			.phv_in(stg_phv[i]), .phv_in_valid(stg_valid[i]),
			.ctrl_in(ctrl_chain[i+1]),
			.phv_out(stg_phv[i+1]), .phv_out_valid(stg_valid[i+1])
		);
	end

	// margin covers the PHVs still in the stages
	sync_fifo #(
		.WIDTH($bits(axis_t)), .DEPTH_BITS(FIFO_DEPTH_BITS), .MARGIN(NUM_STAGES + 2)
	) u_pkt_fifo (
		.clk(clk), .aresetn(aresetn), .din(pkt_in), .wr_en(pkt_wr), .rd_en(pkt_rd),
		.dout(pkt_out), .empty(pkt_empty), .nearly_full(pkt_nf)
	);

	sync_fifo #(
		.WIDTH($bits(phv_t)), .DEPTH_BITS(FIFO_DEPTH_BITS), .MARGIN(NUM_STAGES + 2)
	) u_phv_fifo (
		.clk(clk), .aresetn(aresetn),
		.din(stg_phv[NUM_STAGES]), .wr_en(stg_valid[NUM_STAGES]), .rd_en(phv_rd),
		.dout(phv_head), .empty(phv_empty), .nearly_full(phv_nf)
	);

	phv_deparser u_deparser (
		.clk(clk), .aresetn(aresetn),
		.pkt_beat(pkt_out), .pkt_empty(pkt_empty), .pkt_rd(pkt_rd),
		.phv(phv_head), .phv_empty(phv_empty), .phv_rd(phv_rd),
		.m_axis(m_beat), .m_valid(m_axis_tvalid), .m_ready(m_axis_tready)
	);

endmodule

/* tb/tb_rmt.sv */
module tb_rmt import rmt_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam string VEC_FILE = "tb/rmt_vectors.txt";
	// watchdog budget per record
	localparam int CYCLES_PER_REC = 40;
	// quiet time after the last expected beat, catches extra beats
	localparam int DRAIN_CYCLES = 20;

	// one input record, a beat or a new flags word
	typedef struct packed {
		logic        is_flags;
		logic [31:0] flags;
		axis_t       beat;
	} stim_t;

	logic        clk;
	logic        aresetn;
	logic [31:0] vlan_drop_flags;
	logic [31:0] ctrl_token;
	beat_t       s_axis_tdata;
	keep_t       s_axis_tkeep;
	logic        s_axis_tvalid;
	logic        s_axis_tready;
	logic        s_axis_tlast;
	beat_t       m_axis_tdata;
	keep_t       m_axis_tkeep;
	logic        m_axis_tvalid;
	logic        m_axis_tready;
	logic        m_axis_tlast;

	stim_t stim_q[$];
	axis_t exp_q[$];
	int    exp_token = 0;
	int    n_records = 0;
	int    n_checked = 0;
	logic  loaded = 1'b0;
	int    seed = 32'hba552a22;

	rmt_top dut (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.ctrl_token(ctrl_token),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tkeep(s_axis_tkeep),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tkeep(m_axis_tkeep),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast)
	);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task automatic end_with_failure(input string why);
		$display("Test failed");
		$fatal(1, "%s", why);
	endtask

	// fill stim_q, exp_q and exp_token from the vectors file
	task automatic read_vectors();
		int          fd;
		int          ch;
		int          n;
		logic        ok;
		logic [7:0]  tag;
		logic [63:0] data;
		logic [7:0]  keep;
		logic [3:0]  last;
		stim_t       s;
		fd = $fopen(VEC_FILE, "r");
		assert (fd != 0) else begin
			$display("cannot open the vectors file %s", VEC_FILE);
			end_with_failure("vectors file missing");
		end
		while ($fscanf(fd, " %s", tag) == 1) begin
			if (tag == "#") begin
				// comment runs to end of line
				ch = $fgetc(fd);
				while (ch != 'h0a && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				n_records++;
				s = '0;
				case (tag)
					"F": begin
						n = $fscanf(fd, " %h", data);
						ok = n == 1;
						s.is_flags = 1'b1;
						s.flags = data[31:0];
						stim_q.push_back(s);
					end
					"I", "E": begin
						n = $fscanf(fd, " %h %h %h", data, keep, last);
						ok = n == 3;
						s.beat = '{data: data, keep: keep, last: last[0]};
						if (tag == "I") begin
							stim_q.push_back(s);
						end else begin
							exp_q.push_back(s.beat);
						end
					end
					"T": begin
						n = $fscanf(fd, " %d", exp_token);
						ok = n == 1;
					end
					default: ok = 1'b0;
				endcase
				assert (ok) else begin
					$display("record %0d of the vectors file is malformed", n_records);
					end_with_failure("bad vectors file");
				end
			end
		end
		$fclose(fd);
	endtask

	// holds the beat until the DUT takes it
	task automatic send_beat(input axis_t b);
		s_axis_tdata <= b.data;
		s_axis_tkeep <= b.keep;
		s_axis_tlast <= b.last;
		s_axis_tvalid <= 1'b1;
		// tready moves on rising edges only, falling edge shows the coming handshake
		do begin
			@(negedge clk);
		end while (!s_axis_tready);
		@(posedge clk);
	endtask

	task automatic check_beat();
		axis_t e;
		assert (exp_q.size() != 0) else begin
			$display("output beat %0d arrived with no beat left to expect", n_checked);
			end_with_failure("extra output beat");
		end
		e = exp_q.pop_front();
		assert (m_axis_tdata == e.data) else begin
			$display("[FAIL] m_axis_tdata beat %0d: got %h, expected %h",
				n_checked, m_axis_tdata, e.data);
			end_with_failure("m_axis_tdata mismatch");
		end
		assert (m_axis_tkeep == e.keep) else begin
			$display("[FAIL] m_axis_tkeep beat %0d: got %h, expected %h",
				n_checked, m_axis_tkeep, e.keep);
			end_with_failure("m_axis_tkeep mismatch");
		end
		assert (m_axis_tlast == e.last) else begin
			$display("[FAIL] m_axis_tlast beat %0d: got %h, expected %h",
				n_checked, m_axis_tlast, e.last);
			end_with_failure("m_axis_tlast mismatch");
		end
		n_checked++;
	endtask

	// random sink stalls, ready about three cycles in four
	initial begin
		forever begin
			@(posedge clk);
			m_axis_tready <= ($random(seed) & 3) != 0;
		end
	end

	// output monitor, values settled at the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (aresetn && m_axis_tvalid && m_axis_tready) begin
				check_beat();
			end
		end
	end

	// watchdog scaled to the vector count
	initial begin
		wait (loaded);
		repeat (CYCLES_PER_REC * n_records) @(posedge clk);
		$display("timeout after %0d cycles, %0d output beats never arrived",
			CYCLES_PER_REC * n_records, exp_q.size());
		end_with_failure("watchdog timeout");
	end

	initial begin
		stim_t s;
		aresetn = 1'b0;
		vlan_drop_flags = '0;
		s_axis_tdata = '0;
		s_axis_tkeep = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		m_axis_tready = 1'b0;
		read_vectors();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		aresetn <= 1'b1;
		while (stim_q.size() != 0) begin
			s = stim_q.pop_front();
			if (s.is_flags) begin
				// flags records sit between packets in the file
				vlan_drop_flags <= s.flags;
			end else begin
				send_beat(s.beat);
			end
		end
		s_axis_tvalid <= 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (DRAIN_CYCLES) @(posedge clk);
		assert (ctrl_token == 32'(exp_token)) else begin
			$display("[FAIL] ctrl_token: got %h, expected %h", ctrl_token, 32'(exp_token));
		end
		if (ctrl_token == 32'(exp_token)) begin
			$display("Test passed");
			$finish;
		end else begin
			end_with_failure("ctrl_token mismatch");
		end
	end

endmodule

/* sim.f */
hw/rmt_pkg.sv
hw/sync_fifo.sv
hw/pkt_filter.sv
hw/phv_parser.sv
hw/match_stage.sv
hw/phv_deparser.sv
hw/rmt_top.sv
tb/tb_rmt.sv

/* Makefile */
# Verilator build of the match-action pipeline testbench

SIM := obj_dir/Vtb_rmt

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_rmt -f sim.f

run: build
	./$(SIM)

lint:
	verilator --lint-only --timing --assert --top-module tb_rmt -f sim.f

clean:
	rm -rf obj_dir

/* tb/rmt_vectors.txt */
# F flags | I data keep last (input beat) | E data keep last (expected output beat)
# T final ctrl_token in decimal, everything else in hex
# tables at reset, single and multi-beat data pass unchanged
F 00000000
I 0800005011112222 ff 1
E 0800005011112222 ff 1
I 0800003012345678 ff 0
I 0123456789abcdef ff 0
I fedcba9876543210 0f 1
E 0800003012345678 ff 0
E 0123456789abcdef ff 0
E fedcba9876543210 0f 1
# unknown type, then vlans 0x005 and 0x025 blocked by flag 5
I 86dd005000001111 ff 0
I 5555555555555555 ff 1
F 00000020
I 08000050aaaabbbb ff 0
I 1111111111111111 03 1
I 08000250ccccdddd ff 1
I 0800003000010002 ff 1
E 0800003000010002 ff 1
F 00000000
I 08000050aaaabbbb ff 0
I 1111111111111111 03 1
E 08000050aaaabbbb ff 0
E 1111111111111111 03 1
# stage 0 add c0, stage 2 set c1, stage 3 add c1 on entry 5, stage 1 set c0 on entry 7
I f1f2054002000000 ff 1
I f1f225b579a00000 ff 1
I f1f2356000200000 ff 1
I f1f2178eeee00000 ff 1
I 0800005011112222 ff 1
E 080000501121abce ff 1
I 08000150fff8ffff ff 0
I 00000000deadbeef 3f 1
E 080001500008abce ff 0
E 00000000deadbeef 3f 1
I 0800007a55556666 ff 1
E 0800007a77776666 ff 1
I 08000030abcd1234 ff 1
E 08000030abcd1234 ff 1
T 4
